// ==== Bender.yml ====
package:
  name: tile_mem_hub

sources:
  - source/tile_pkg.sv
  - source/mem_cmd_decode.sv
  - source/cfg_regs.sv
  - source/clint_timer.sv
  - source/mem_loopback.sv
  - source/mem_resp_arb.sv
  - source/tile_mem_hub.sv
  - target: simulation
    files:
      - bench/tile_mem_hub_chk.sv
      - bench/tile_mem_hub_tb.sv

// ==== bench/tile_mem_hub_chk.sv ====
// Bound assertions for the tile memory hub; attached to every tile_mem_hub instance by bind
module tile_mem_hub_chk
  import tile_pkg::*;
  (input               clk_i
   , input             rst_i
   , input             cmd_v_i
   , input             cmd_ready_i
   , input mem_resp_s  resp_i
   , input             resp_v_i
   , input             resp_ready_i
   , input             cfg_yumi_i
   , input             clint_yumi_i
   , input             loop_yumi_i
   );

  int fails = 0;

  // A stalled response only changes when a new command is accepted
  resp_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_v_i && !resp_ready_i && !(cmd_v_i && cmd_ready_i) |=> resp_v_i && $stable(resp_i))
  else
  begin
    $error("response changed or dropped while stalled");
    fails++;
  end

  yumi_onehot_a: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({cfg_yumi_i, clint_yumi_i, loop_yumi_i}))
  else
  begin
    $error("more than one device got a yumi");
    fails++;
  end

  reset_idle_a: assert property (@(posedge clk_i) rst_i |=> !resp_v_i)
  else
  begin
    $error("response valid right after reset");
    fails++;
  end

endmodule

bind tile_mem_hub tile_mem_hub_chk chk
  (.clk_i(clk_i)
   ,.rst_i(rst_i)
   ,.cmd_v_i(cmd_v_i)
   ,.cmd_ready_i(cmd_ready_o)
   ,.resp_i(resp_o)
   ,.resp_v_i(resp_v_o)
   ,.resp_ready_i(resp_ready_i)
   ,.cfg_yumi_i(cfg_yumi)
   ,.clint_yumi_i(clint_yumi)
   ,.loop_yumi_i(loop_yumi)
   );

// ==== bench/tile_mem_hub_tb.sv ====
// Directed testbench for the tile memory hub; run as the simulation top with the file list
module tile_mem_hub_tb;
  import tile_pkg::*;

  localparam int max_cycles_c = 2000;
  localparam logic [did_width_c-1:0] did_c      = 16'h00a5;
  localparam logic [did_width_c-1:0] host_did_c = 16'h0003;

  logic                    clk_i;
  logic                    rst_i;
  logic [did_width_c-1:0]  did_i;
  logic [did_width_c-1:0]  host_did_i;
  mem_cmd_s                cmd_i;
  logic                    cmd_v_i;
  logic                    cmd_ready_o;
  mem_resp_s               resp_o;
  logic                    resp_v_o;
  logic                    resp_ready_i;
  logic                    freeze_o;
  logic                    timer_irq_o;
  logic                    software_irq_o;

  int errors = 0;
  int cycles = 0;

  tile_mem_hub dut_i
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.did_i(did_i)
     ,.host_did_i(host_did_i)
     ,.cmd_i(cmd_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_ready_o(cmd_ready_o)
     ,.resp_o(resp_o)
     ,.resp_v_o(resp_v_o)
     ,.resp_ready_i(resp_ready_i)
     ,.freeze_o(freeze_o)
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles >= max_cycles_c)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", max_cycles_c);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected)
    begin
      errors++;
      $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  function automatic logic [addr_width_c-1:0] local_addr(input logic [3:0] dev,
                                                         input logic [19:0] offset);
    return {16'h0, dev, offset};
  endfunction

  // Returns on the falling edge after the accept
  task automatic send_cmd(input mem_opcode_e op, input logic [addr_width_c-1:0] addr,
                          input logic [data_width_c-1:0] data);
    @(negedge clk_i);
    cmd_i   = '{opcode: op, addr: addr, data: data};
    cmd_v_i = 1'b1;
    #1;
    while (!cmd_ready_o)
    begin
      @(negedge clk_i);
      #1;
    end
    @(posedge clk_i);
    @(negedge clk_i);
    cmd_v_i = 1'b0;
  endtask

  // Samples away from the rising edge, then lets the response be taken
  task automatic get_resp(output mem_resp_s r);
    while (!resp_v_o)
      @(negedge clk_i);
    r = resp_o;
    @(posedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic access(input mem_opcode_e op, input logic [addr_width_c-1:0] addr,
                        input logic [data_width_c-1:0] wdata,
                        output logic [data_width_c-1:0] rdata);
    mem_resp_s r;
    send_cmd(op, addr, wdata);
    get_resp(r);
    check_value("resp_o.opcode", 64'(op), 64'(r.opcode));
    check_value("resp_o.addr", 64'(addr), 64'(r.addr));
    if (op == e_mem_wr)
      check_value("resp_o.data", '0, r.data);
    rdata = r.data;
  endtask

  // Called as the write access returns, one cycle after mtimecmp changed
  task automatic wait_timer_irq(input logic level);
    int n;
    n = 0;
    while ((timer_irq_o !== level) && (n < 1))
    begin
      @(negedge clk_i);
      n++;
    end
    check_value("timer_irq_o", 64'(level), 64'(timer_irq_o));
  endtask

  task automatic test_reset();
    logic [63:0] d;
    check_value("freeze_o", 1, 64'(freeze_o));
    check_value("timer_irq_o", 0, 64'(timer_irq_o));
    check_value("software_irq_o", 0, 64'(software_irq_o));
    access(e_mem_rd, local_addr(cfg_dev_c, cfg_did_c), '0, d);
    check_value("cfg did", 64'(did_c), d);
    access(e_mem_rd, local_addr(cfg_dev_c, cfg_host_did_c), '0, d);
    check_value("cfg host did", 64'(host_did_c), d);
    access(e_mem_rd, local_addr(cfg_dev_c, cfg_freeze_c), '0, d);
    check_value("cfg freeze", 1, d);
  endtask

  task automatic test_cfg_write();
    logic [63:0] d;
    access(e_mem_wr, local_addr(cfg_dev_c, cfg_freeze_c), '0, d);
    check_value("freeze_o", 0, 64'(freeze_o));
    access(e_mem_rd, local_addr(cfg_dev_c, cfg_freeze_c), '0, d);
    check_value("cfg freeze", 0, d);
    access(e_mem_wr, local_addr(cfg_dev_c, cfg_did_c), {$urandom, $urandom}, d);
    access(e_mem_rd, local_addr(cfg_dev_c, cfg_did_c), '0, d);
    check_value("cfg did", 64'(did_c), d);
  endtask

  task automatic test_clint();
    logic [63:0] d;
    logic [63:0] t0;
    logic [63:0] t1;
    access(e_mem_wr, local_addr(clint_dev_c, clint_msip_c), 64'h1, d);
    check_value("software_irq_o", 1, 64'(software_irq_o));
    access(e_mem_wr, local_addr(clint_dev_c, clint_msip_c), 64'h0, d);
    check_value("software_irq_o", 0, 64'(software_irq_o));
    access(e_mem_wr, local_addr(clint_dev_c, clint_mtimecmp_c), 64'h0, d);
    wait_timer_irq(1'b1);
    access(e_mem_wr, local_addr(clint_dev_c, clint_mtimecmp_c), '1, d);
    wait_timer_irq(1'b0);
    access(e_mem_rd, local_addr(clint_dev_c, clint_mtime_c), '0, t0);
    repeat (20) @(negedge clk_i);
    access(e_mem_rd, local_addr(clint_dev_c, clint_mtime_c), '0, t1);
    // Twenty idle clocks span several prescale periods
    if (t1 <= t0)
    begin
      errors++;
      $display("Error at %0t: mtime did not advance, read %h then %h", $time, t0, t1);
    end
  endtask

  task automatic test_loopback();
    logic [addr_width_c-1:0] addr;
    logic [3:0]              dev;
    logic [63:0]             d;
    mem_opcode_e             op;
    for (int i = 0; i < 8; i++)
    begin
      // Odd rounds hit DRAM space, even rounds an unmapped local device
      if (i % 2)
        addr = {8'($urandom), 32'($urandom)} | 40'h00_8000_0000;
      else
      begin
        dev = 4'($urandom);
        if ((dev == clint_dev_c) || (dev == cfg_dev_c))
          dev = dev + 4'd3;
        addr = {9'h0, 7'($urandom), dev, 20'($urandom)};
      end
      op = ($urandom % 2) ? e_mem_wr : e_mem_rd;
      access(op, addr, {$urandom, $urandom}, d);
      check_value("loopback data", '0, d);
    end
  endtask

  task automatic test_backpressure();
    logic [addr_width_c-1:0] loop_addr;
    mem_resp_s               r;
    loop_addr = {8'($urandom), 32'($urandom)} | 40'h00_8000_0000;
    @(negedge clk_i);
    resp_ready_i = 1'b0;
    send_cmd(e_mem_rd, loop_addr, '0);
    send_cmd(e_mem_rd, local_addr(clint_dev_c, clint_mtimecmp_c), '0);
    send_cmd(e_mem_rd, local_addr(cfg_dev_c, cfg_did_c), '0);
    // A second cfg command must stall behind the held response
    @(negedge clk_i);
    cmd_i   = '{opcode: e_mem_rd, addr: local_addr(cfg_dev_c, cfg_host_did_c), data: '0};
    cmd_v_i = 1'b1;
    #1;
    check_value("cmd_ready_o", 0, 64'(cmd_ready_o));
    cmd_v_i      = 1'b0;
    resp_ready_i = 1'b1;
    get_resp(r);
    check_value("cfg resp addr", 64'(local_addr(cfg_dev_c, cfg_did_c)), 64'(r.addr));
    check_value("cfg resp data", 64'(did_c), r.data);
    get_resp(r);
    check_value("clint resp addr", 64'(local_addr(clint_dev_c, clint_mtimecmp_c)), 64'(r.addr));
    check_value("clint resp data", '1, r.data);
    get_resp(r);
    check_value("loop resp addr", 64'(loop_addr), 64'(r.addr));
    check_value("loop resp data", '0, r.data);
  endtask

  initial
  begin
    void'($urandom(32'hb599fe59));
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    did_i        = did_c;
    host_did_i   = host_did_c;
    cmd_i        = '0;
    cmd_v_i      = 1'b0;
    resp_ready_i = 1'b1;
    repeat (2) @(negedge clk_i);
    rst_i = 1'b0;
    test_reset();
    test_cfg_write();
    test_clint();
    test_loopback();
    test_backpressure();
    repeat (2) @(negedge clk_i);
    $display("Errors: %0d check(s), %0d assertion(s)", errors, dut_i.chk.fails);
    if ((errors == 0) && (dut_i.chk.fails == 0))
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== files.f ====
source/tile_pkg.sv
source/mem_cmd_decode.sv
source/cfg_regs.sv
source/clint_timer.sv
source/mem_loopback.sv
source/mem_resp_arb.sv
source/tile_mem_hub.sv
bench/tile_mem_hub_chk.sv
bench/tile_mem_hub_tb.sv

// ==== source/cfg_regs.sv ====
// Tile configuration block; holds the freeze bit and reports the tile and host device ids
module cfg_regs
  import tile_pkg::*;
  (input                           clk_i
   , input                         rst_i

   , input mem_cmd_s               cmd_i
   , input                         v_i
   , output logic                  ready_o

   , output mem_resp_s             resp_o
   , output logic                  resp_v_o
   , input                         yumi_i

   , input [did_width_c-1:0]       did_i
   , input [did_width_c-1:0]       host_did_i
   , output logic                  freeze_o
   );

  resp_state_e              state_r;
  mem_resp_s                resp_r;
  logic                     freeze_r;
  logic [dev_lsb_c-1:0]     offset;
  logic [data_width_c-1:0]  rd_data;
  logic                     is_wr;

  assign offset = cmd_i.addr[dev_lsb_c-1:0];
  assign is_wr  = (cmd_i.opcode == e_mem_wr);

  always_comb
  begin
    case (offset)
      cfg_freeze_c:   rd_data = data_width_c'(freeze_r);
      cfg_did_c:      rd_data = data_width_c'(did_i);
      cfg_host_did_c: rd_data = data_width_c'(host_did_i);
      default:        rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r  <= e_idle;
      freeze_r <= 1'b1;
    end
    else
    begin
      if (v_i)
        state_r <= e_resp;
      else if (yumi_i)
        state_r <= e_idle;

      // Only freeze is writable, id offsets ignore writes
      if (v_i && is_wr && (offset == cfg_freeze_c))
        freeze_r <= cmd_i.data[0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (v_i)
      resp_r <= '{opcode: cmd_i.opcode, addr: cmd_i.addr, data: is_wr ? '0 : rd_data};
  end

  assign ready_o  = (state_r == e_idle);
  assign resp_v_o = (state_r == e_resp);
  assign resp_o   = resp_r;
  assign freeze_o = freeze_r;

endmodule

// ==== source/clint_timer.sv ====
// Core-local interruptor with machine timer, timer compare and software interrupt registers
module clint_timer
  import tile_pkg::*;
  #(parameter int timer_div_p = 4)
  (input                  clk_i
   , input                rst_i

   , input mem_cmd_s      cmd_i
   , input                v_i
   , output logic         ready_o

   , output mem_resp_s    resp_o
   , output logic         resp_v_o
   , input                yumi_i

   , output logic         timer_irq_o
   , output logic         software_irq_o
   );

  localparam int div_width_lp = (timer_div_p > 1) ? $clog2(timer_div_p) : 1;

  resp_state_e              state_r;
  mem_resp_s                resp_r;
  logic [div_width_lp-1:0]  prescale_r;
  logic                     tick;
  logic [data_width_c-1:0]  mtime_r;
  logic [data_width_c-1:0]  mtimecmp_r;
  logic                     msip_r;
  logic                     timer_irq_r;
  logic [dev_lsb_c-1:0]     offset;
  logic [data_width_c-1:0]  rd_data;
  logic                     is_wr;

  assign offset = cmd_i.addr[dev_lsb_c-1:0];
  assign is_wr  = (cmd_i.opcode == e_mem_wr);
  assign tick   = (prescale_r == div_width_lp'(timer_div_p - 1));

  always_comb
  begin
    case (offset)
      clint_msip_c:     rd_data = data_width_c'(msip_r);
      clint_mtimecmp_c: rd_data = mtimecmp_r;
      clint_mtime_c:    rd_data = mtime_r;
      default:          rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r     <= e_idle;
      prescale_r  <= '0;
      mtime_r     <= '0;
      mtimecmp_r  <= '1;
      msip_r      <= 1'b0;
      timer_irq_r <= 1'b0;
    end
    else
    begin
      if (v_i)
        state_r <= e_resp;
      else if (yumi_i)
        state_r <= e_idle;

      prescale_r <= tick ? '0 : prescale_r + 1'b1;

      // A write to mtime wins over the tick in the same cycle
      if (v_i && is_wr && (offset == clint_mtime_c))
        mtime_r <= cmd_i.data;
      else if (tick)
        mtime_r <= mtime_r + 1'b1;

      if (v_i && is_wr && (offset == clint_mtimecmp_c))
        mtimecmp_r <= cmd_i.data;

      if (v_i && is_wr && (offset == clint_msip_c))
        msip_r <= cmd_i.data[0];

      timer_irq_r <= (mtime_r >= mtimecmp_r);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (v_i)
      resp_r <= '{opcode: cmd_i.opcode, addr: cmd_i.addr, data: is_wr ? '0 : rd_data};
  end

  assign ready_o        = (state_r == e_idle);
  assign resp_v_o       = (state_r == e_resp);
  assign resp_o         = resp_r;
  assign timer_irq_o    = timer_irq_r;
  assign software_irq_o = msip_r;

endmodule

// ==== source/mem_cmd_decode.sv ====
// Command address decoder; steers the shared command valid to one device and returns its ready
module mem_cmd_decode
  import tile_pkg::*;
  (input mem_cmd_s  cmd_i
   , input          cmd_v_i
   , output logic   cmd_ready_o

   , input          cfg_ready_i
   , input          clint_ready_i
   , input          loop_ready_i

   , output logic   cfg_v_o
   , output logic   clint_v_o
   , output logic   loop_v_o
   );

  dev_sel_e                 sel;
  logic                     is_local;
  logic [dev_width_c-1:0]   dev_field;

  assign is_local  = (cmd_i.addr < dram_base_c);
  assign dev_field = cmd_i.addr[dev_lsb_c+:dev_width_c];

  // Cache space and unmapped devices all land on the loopback
  always_comb
  begin
    if (is_local && (dev_field == cfg_dev_c))
      sel = e_sel_cfg;
    else if (is_local && (dev_field == clint_dev_c))
      sel = e_sel_clint;
    else
      sel = e_sel_loop;
  end

  always_comb
  begin
    case (sel)
      e_sel_cfg:   cmd_ready_o = cfg_ready_i;
      e_sel_clint: cmd_ready_o = clint_ready_i;
      default:     cmd_ready_o = loop_ready_i;
    endcase
  end

  // Valid doubles as accept, so devices need not check ready themselves
  assign cfg_v_o   = cmd_v_i & cfg_ready_i & (sel == e_sel_cfg);
  assign clint_v_o = cmd_v_i & clint_ready_i & (sel == e_sel_clint);
  assign loop_v_o  = cmd_v_i & loop_ready_i & (sel == e_sel_loop);

endmodule

// ==== source/mem_loopback.sv ====
// Loopback responder for unmapped and cache addresses; echoes the command with zero data
module mem_loopback
  import tile_pkg::*;
  (input                  clk_i
   , input                rst_i

   , input mem_cmd_s      cmd_i
   , input                v_i
   , output logic         ready_o

   , output mem_resp_s    resp_o
   , output logic         resp_v_o
   , input                yumi_i
   );

  resp_state_e  state_r;
  mem_resp_s    resp_r;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      state_r <= e_idle;
    else if (v_i)
      state_r <= e_resp;
    else if (yumi_i)
      state_r <= e_idle;
  end

  always_ff @(posedge clk_i)
  begin
    if (v_i)
      resp_r <= '{opcode: cmd_i.opcode, addr: cmd_i.addr, data: '0};
  end

  assign ready_o  = (state_r == e_idle);
  assign resp_v_o = (state_r == e_resp);
  assign resp_o   = resp_r;

endmodule

// ==== source/mem_resp_arb.sv ====
// Fixed-priority response merge; cfg first, then clint, then loopback, with yumi back to the winner
module mem_resp_arb
  import tile_pkg::*;
  (input mem_resp_s       cfg_resp_i
   , input                cfg_v_i
   , output logic         cfg_yumi_o

   , input mem_resp_s     clint_resp_i
   , input                clint_v_i
   , output logic         clint_yumi_o

   , input mem_resp_s     loop_resp_i
   , input                loop_v_i
   , output logic         loop_yumi_o

   , output mem_resp_s    resp_o
   , output logic         resp_v_o
   , input                resp_ready_i
   );

  logic cfg_grant, clint_grant, loop_grant;

  assign cfg_grant   = cfg_v_i;
  assign clint_grant = clint_v_i & ~cfg_v_i;
  assign loop_grant  = loop_v_i & ~cfg_v_i & ~clint_v_i;

  always_comb
  begin
    if (cfg_grant)
      resp_o = cfg_resp_i;
    else if (clint_grant)
      resp_o = clint_resp_i;
    else
      resp_o = loop_resp_i;
  end

  assign resp_v_o = cfg_v_i | clint_v_i | loop_v_i;

  assign cfg_yumi_o   = cfg_grant & resp_ready_i;
  assign clint_yumi_o = clint_grant & resp_ready_i;
  assign loop_yumi_o  = loop_grant & resp_ready_i;

endmodule

// ==== source/tile_mem_hub.sv ====
// Top level of the tile memory hub; joins the decoder, the three devices and the response arbiter
module tile_mem_hub
  import tile_pkg::*;
  #(parameter int timer_div_p = 4)
  (input                        clk_i
   , input                      rst_i

   , input [did_width_c-1:0]    did_i
   , input [did_width_c-1:0]    host_did_i

   , input mem_cmd_s            cmd_i
   , input                      cmd_v_i
   , output logic               cmd_ready_o

   , output mem_resp_s          resp_o
   , output logic               resp_v_o
   , input                      resp_ready_i

   , output logic               freeze_o
   , output logic               timer_irq_o
   , output logic               software_irq_o
   );

  logic       cfg_v, clint_v, loop_v;
  logic       cfg_ready, clint_ready, loop_ready;
  mem_resp_s  cfg_resp, clint_resp, loop_resp;
  logic       cfg_resp_v, clint_resp_v, loop_resp_v;
  logic       cfg_yumi, clint_yumi, loop_yumi;

  mem_cmd_decode decode
    (.cmd_i(cmd_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_ready_o(cmd_ready_o)
     ,.cfg_ready_i(cfg_ready)
     ,.clint_ready_i(clint_ready)
     ,.loop_ready_i(loop_ready)
     ,.cfg_v_o(cfg_v)
     ,.clint_v_o(clint_v)
     ,.loop_v_o(loop_v)
     );

  cfg_regs cfg
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.cmd_i(cmd_i)
     ,.v_i(cfg_v)
     ,.ready_o(cfg_ready)
     ,.resp_o(cfg_resp)
     ,.resp_v_o(cfg_resp_v)
     ,.yumi_i(cfg_yumi)
     ,.did_i(did_i)
     ,.host_did_i(host_did_i)
     ,.freeze_o(freeze_o)
     );

  clint_timer #(.timer_div_p(timer_div_p)) clint
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.cmd_i(cmd_i)
     ,.v_i(clint_v)
     ,.ready_o(clint_ready)
     ,.resp_o(clint_resp)
     ,.resp_v_o(clint_resp_v)
     ,.yumi_i(clint_yumi)
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

  mem_loopback loopback
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.cmd_i(cmd_i)
     ,.v_i(loop_v)
     ,.ready_o(loop_ready)
     ,.resp_o(loop_resp)
     ,.resp_v_o(loop_resp_v)
     ,.yumi_i(loop_yumi)
     );

  mem_resp_arb resp_arb
    (.cfg_resp_i(cfg_resp)
     ,.cfg_v_i(cfg_resp_v)
     ,.cfg_yumi_o(cfg_yumi)
     ,.clint_resp_i(clint_resp)
     ,.clint_v_i(clint_resp_v)
     ,.clint_yumi_o(clint_yumi)
     ,.loop_resp_i(loop_resp)
     ,.loop_v_i(loop_resp_v)
     ,.loop_yumi_o(loop_yumi)
     ,.resp_o(resp_o)
     ,.resp_v_o(resp_v_o)
     ,.resp_ready_i(resp_ready_i)
     );

endmodule

// ==== source/tile_pkg.sv ====
// Shared types and address map for the tile memory hub, imported by every RTL module
package tile_pkg;

  localparam int addr_width_c = 40;
  localparam int data_width_c = 64;
  localparam int did_width_c  = 16;

  // Everything below this address is tile-local
  localparam logic [addr_width_c-1:0] dram_base_c = 40'h00_8000_0000;

  // Device field of a local address, bits 23 to 20
  localparam int dev_lsb_c   = 20;
  localparam int dev_width_c = 4;

  localparam logic [dev_width_c-1:0] cfg_dev_c   = 4'd2;
  localparam logic [dev_width_c-1:0] clint_dev_c = 4'd1;

  // Register offsets, address bits 19 to 0
  localparam logic [dev_lsb_c-1:0] cfg_freeze_c   = 20'h0;
  localparam logic [dev_lsb_c-1:0] cfg_did_c      = 20'h8;
  localparam logic [dev_lsb_c-1:0] cfg_host_did_c = 20'h10;

  localparam logic [dev_lsb_c-1:0] clint_msip_c     = 20'h0;
  localparam logic [dev_lsb_c-1:0] clint_mtimecmp_c = 20'h8;
  localparam logic [dev_lsb_c-1:0] clint_mtime_c    = 20'h10;

  typedef enum logic [0:0]
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_opcode_e;

  typedef enum logic [1:0]
  {
    e_sel_cfg   = 2'd0,
    e_sel_clint = 2'd1,
    e_sel_loop  = 2'd2
  } dev_sel_e;

  typedef enum logic [0:0]
  {
    e_idle = 1'b0,
    e_resp = 1'b1
  } resp_state_e;

  typedef struct packed
  {
    mem_opcode_e              opcode;
    logic [addr_width_c-1:0]  addr;
    logic [data_width_c-1:0]  data;
  } mem_cmd_s;

  // Data is read data on reads and zero on writes
  typedef struct packed
  {
    mem_opcode_e              opcode;
    logic [addr_width_c-1:0]  addr;
    logic [data_width_c-1:0]  data;
  } mem_resp_s;

endpackage
